// File: include/plic_macros.svh
// Interrupt controller sizes and register offsets, included by every RTL file that needs them
`ifndef PLIC_MACROS_SVH
`define PLIC_MACROS_SVH

// Number of level-triggered sources, ids 1..N
`define PLIC_NUM_SOURCES 4

// AXI4-Lite address width
`define PLIC_ADDR_WIDTH 24

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register map, single hart context
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define PLIC_ADDR_PENDING 24'h001000 // Read only, bit 0 always zero
`define PLIC_ADDR_ENABLE  24'h002000 // Bit 0 ignored
`define PLIC_ADDR_CLAIM   24'h200004 // Read claims, write completes

`endif

// File: src/plic_pkg.sv
// Shared enum types for the interrupt controller, imported by the slave, arbiter and top level
`default_nettype none

package plic_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// AXI4-Lite slave FSM
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [1:0] {
		axil_idle       = 2'd0, // Ready for a new address
		axil_write_resp = 2'd1, // Holding bvalid
		axil_read_wait  = 2'd2, // Claim result not back yet
		axil_read_resp  = 2'd3  // Holding rvalid
	} axil_state_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Operation from slave to arbiter
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [1:0] {
		op_none     = 2'd0,
		op_claim    = 2'd1, // Read of the claim word
		op_complete = 2'd2  // Write of the claim word
	} reg_op_t;

endpackage

`default_nettype wire

// File: src/plic_gateway.sv
// First stage: synchronizes the raw interrupt lines and masks them into request bits
`timescale 1ns/1ns
`default_nettype none

`include "plic_macros.svh"

module plic_gateway (
	input  logic                         i_clock,
	input  logic                         i_reset,
	input  logic [`PLIC_NUM_SOURCES-1:0] i_sources,
	input  logic [`PLIC_NUM_SOURCES-1:0] i_enable,
	input  logic                         i_interrupt_enable,
	output logic [`PLIC_NUM_SOURCES-1:0] o_request
);

	localparam int num_src = `PLIC_NUM_SOURCES;

	logic [num_src-1:0] sync_meta; // First flop, may go metastable
	logic [num_src-1:0] sync_level; // Second flop, safe to use

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Two-flop synchronizer
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			sync_meta <= '0;
			sync_level <= '0;
		end
		else begin
			sync_meta <= i_sources;
			sync_level <= sync_meta;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Masked request
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// A level source keeps requesting for as long as it is high
	// and the pending bit downstream holds it until a claim
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_request <= '0;
		end
		else if (i_interrupt_enable) begin
			o_request <= sync_level & i_enable;
		end
		else begin
			o_request <= '0; // Hart has interrupts off
		end
	end

endmodule

`default_nettype wire

// File: src/plic_pending_arbiter.sv
// Second stage: keeps the pending bits, answers claims by lowest id and drives the interrupt pulse
`timescale 1ns/1ns
`default_nettype none

`include "plic_macros.svh"

module plic_pending_arbiter (
	input  logic                         i_clock,
	input  logic                         i_reset,
	input  logic [`PLIC_NUM_SOURCES-1:0] i_request,
	input  logic                         i_interrupt_enable,
	input  plic_pkg::reg_op_t            i_op,
	output logic [`PLIC_NUM_SOURCES-1:0] o_pending,
	output logic [31:0]                  o_claim_id,
	output logic                         o_claim_valid,
	output logic                         o_interrupt
);

	import plic_pkg::*;

	localparam int num_src = `PLIC_NUM_SOURCES;

	logic [num_src-1:0] pending;
	logic [num_src-1:0] claim_mask; // Lowest set pending bit only
	logic [31:0]        lowest_id;  // 0 when nothing pending
	logic               issued;     // Notification out, waiting for complete
	logic               fire;

	assign o_pending = pending;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Fixed priority by index
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Two's complement trick isolates the lowest set bit
	assign claim_mask = pending & (~pending + 1'b1);

	always_comb begin
		lowest_id = '0;
		// Walk down so the lowest index wins
		for (int i = num_src - 1; i >= 0; i--) begin
			if (pending[i]) begin
				lowest_id = 32'(i + 1); // Id n is input bit n-1
			end
		end
	end

	assign fire = i_interrupt_enable && (|pending) && !issued;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Pending, issued and pulse
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			pending <= '0;
			issued <= 1'b0;
			o_interrupt <= 1'b0;
			o_claim_valid <= 1'b0;
		end
		else begin
			// Requests from other sources still land during a claim
			if (i_op == op_claim) begin
				pending <= (pending | i_request) & ~claim_mask;
			end
			else begin
				pending <= pending | i_request;
			end

			o_claim_valid <= (i_op == op_claim); // Answer on the next cycle

			if (fire) begin
				o_interrupt <= 1'b1;
				issued <= 1'b1;
			end
			else begin
				o_interrupt <= 1'b0; // Pulse is one cycle only
				if (i_op == op_complete) begin
					issued <= 1'b0; // Rearm
				end
			end
		end
	end

	// Claim result, qualified by o_claim_valid
	always_ff @(posedge i_clock) begin
		if (i_op == op_claim) begin
			o_claim_id <= lowest_id;
		end
	end

endmodule

`default_nettype wire

// File: src/plic_axil_slave.sv
// Third stage: AXI4-Lite register port, holds the enable word and turns claim accesses into ops
`timescale 1ns/1ns
`default_nettype none

`include "plic_macros.svh"

module plic_axil_slave (
	input  logic                         i_clock,
	input  logic                         i_reset,

	// Write address and data
	input  logic                         i_awvalid,
	output logic                         o_awready,
	input  logic [`PLIC_ADDR_WIDTH-1:0]  i_awaddr,
	input  logic                         i_wvalid,
	output logic                         o_wready,
	input  logic [31:0]                  i_wdata,

	// Write response
	output logic                         o_bvalid,
	input  logic                         i_bready,
	output logic [1:0]                   o_bresp,

	// Read address and data
	input  logic                         i_arvalid,
	output logic                         o_arready,
	input  logic [`PLIC_ADDR_WIDTH-1:0]  i_araddr,
	output logic                         o_rvalid,
	input  logic                         i_rready,
	output logic [31:0]                  o_rdata,
	output logic [1:0]                   o_rresp,

	// Arbiter side
	input  logic [`PLIC_NUM_SOURCES-1:0] i_pending,
	input  logic [31:0]                  i_claim_id,
	input  logic                         i_claim_valid,
	output logic [`PLIC_NUM_SOURCES-1:0] o_enable,
	output plic_pkg::reg_op_t            o_op
);

	import plic_pkg::*;

	localparam int num_src = `PLIC_NUM_SOURCES;
	localparam logic [1:0] resp_okay = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	axil_state_t state;
	logic        write_go;
	logic        read_go;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Handshakes and ops
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Writes take precedence when both arrive together
	assign write_go = (state == axil_idle) && i_awvalid && i_wvalid;
	assign read_go = (state == axil_idle) && i_arvalid && !(i_awvalid && i_wvalid);

	assign o_awready = write_go;
	assign o_wready = write_go; // Address and data taken together
	assign o_arready = read_go;

	// One op per accepted claim access, in the acceptance cycle
	always_comb begin
		o_op = op_none;
		if (write_go && i_awaddr == `PLIC_ADDR_CLAIM) begin
			o_op = op_complete;
		end
		else if (read_go && i_araddr == `PLIC_ADDR_CLAIM) begin
			o_op = op_claim;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// FSM and enable register
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= axil_idle;
			o_bvalid <= 1'b0;
			o_rvalid <= 1'b0;
			o_enable <= '0;
		end
		else begin
			case (state)
				axil_idle: begin
					if (write_go) begin
						if (i_awaddr == `PLIC_ADDR_ENABLE) begin
							o_enable <= i_wdata[num_src:1]; // Bit 0 dropped
						end
						o_bvalid <= 1'b1;
						state <= axil_write_resp;
					end
					else if (read_go) begin
						if (i_araddr == `PLIC_ADDR_CLAIM) begin
							state <= axil_read_wait; // Arbiter answers next cycle
						end
						else begin
							o_rvalid <= 1'b1;
							state <= axil_read_resp;
						end
					end
				end
				axil_write_resp: begin
					if (i_bready) begin
						o_bvalid <= 1'b0;
						state <= axil_idle;
					end
				end
				axil_read_wait: begin
					if (i_claim_valid) begin
						o_rvalid <= 1'b1;
						state <= axil_read_resp;
					end
				end
				axil_read_resp: begin
					if (i_rready) begin
						o_rvalid <= 1'b0;
						state <= axil_idle;
					end
				end
				default: state <= axil_idle;
			endcase
		end
	end

	// Response payload, held while the valids wait for ready
	always_ff @(posedge i_clock) begin
		if (write_go) begin
			if (i_awaddr == `PLIC_ADDR_ENABLE || i_awaddr == `PLIC_ADDR_CLAIM) begin
				o_bresp <= resp_okay;
			end
			else begin
				o_bresp <= resp_slverr; // Pending word is read only
			end
		end

		if (read_go) begin
			case (i_araddr)
				`PLIC_ADDR_ENABLE: begin
					o_rdata <= 32'({o_enable, 1'b0});
					o_rresp <= resp_okay;
				end
				`PLIC_ADDR_PENDING: begin
					o_rdata <= 32'({i_pending, 1'b0});
					o_rresp <= resp_okay;
				end
				`PLIC_ADDR_CLAIM: begin
					o_rresp <= resp_okay; // Data comes from the arbiter
				end
				default: begin
					o_rdata <= '0;
					o_rresp <= resp_slverr;
				end
			endcase
		end
		else if (state == axil_read_wait && i_claim_valid) begin
			o_rdata <= i_claim_id;
		end
	end

endmodule

`default_nettype wire

// File: src/plic_top.sv
// Interrupt controller top level, instantiated by the SoC or the testbench as one block
`timescale 1ns/1ns
`default_nettype none

`include "plic_macros.svh"

module plic_top (
	input  logic                         i_clock,
	input  logic                         i_reset,
	input  logic [`PLIC_NUM_SOURCES-1:0] i_sources,
	input  logic                         i_interrupt_enable,

	// AXI4-Lite slave
	input  logic                         i_awvalid,
	output logic                         o_awready,
	input  logic [`PLIC_ADDR_WIDTH-1:0]  i_awaddr,
	input  logic                         i_wvalid,
	output logic                         o_wready,
	input  logic [31:0]                  i_wdata,
	output logic                         o_bvalid,
	input  logic                         i_bready,
	output logic [1:0]                   o_bresp,
	input  logic                         i_arvalid,
	output logic                         o_arready,
	input  logic [`PLIC_ADDR_WIDTH-1:0]  i_araddr,
	output logic                         o_rvalid,
	input  logic                         i_rready,
	output logic [31:0]                  o_rdata,
	output logic [1:0]                   o_rresp,

	output logic                         o_interrupt
);

	import plic_pkg::*;

	logic [`PLIC_NUM_SOURCES-1:0] request;
	logic [`PLIC_NUM_SOURCES-1:0] enable;
	logic [`PLIC_NUM_SOURCES-1:0] pending;
	logic [31:0]                  claim_id;
	logic                         claim_valid;
	reg_op_t                      op;

	// Synchronize and mask
	plic_gateway gateway_i (
		.i_clock            (i_clock),
		.i_reset            (i_reset),
		.i_sources          (i_sources),
		.i_enable           (enable),
		.i_interrupt_enable (i_interrupt_enable),
		.o_request          (request)
	);

	// Pending and arbitrate
	plic_pending_arbiter arbiter_i (
		.i_clock            (i_clock),
		.i_reset            (i_reset),
		.i_request          (request),
		.i_interrupt_enable (i_interrupt_enable),
		.i_op               (op),
		.o_pending          (pending),
		.o_claim_id         (claim_id),
		.o_claim_valid      (claim_valid),
		.o_interrupt        (o_interrupt)
	);

	// Bus
	plic_axil_slave slave_i (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_awvalid     (i_awvalid),
		.o_awready     (o_awready),
		.i_awaddr      (i_awaddr),
		.i_wvalid      (i_wvalid),
		.o_wready      (o_wready),
		.i_wdata       (i_wdata),
		.o_bvalid      (o_bvalid),
		.i_bready      (i_bready),
		.o_bresp       (o_bresp),
		.i_arvalid     (i_arvalid),
		.o_arready     (o_arready),
		.i_araddr      (i_araddr),
		.o_rvalid      (o_rvalid),
		.i_rready      (i_rready),
		.o_rdata       (o_rdata),
		.o_rresp       (o_rresp),
		.i_pending     (pending),
		.i_claim_id    (claim_id),
		.i_claim_valid (claim_valid),
		.o_enable      (enable),
		.o_op          (op)
	);

endmodule

`default_nettype wire

// File: sim/plic_chk.sv
// Bus and interrupt protocol assertions, bound to the interrupt controller top level by the testbench
`timescale 1ns/1ns
`default_nettype none

module plic_chk (
	input logic              i_clock,
	input logic              i_reset,
	input logic              i_bvalid,
	input logic              i_bready,
	input logic [1:0]        i_bresp,
	input logic              i_rvalid,
	input logic              i_rready,
	input logic [31:0]       i_rdata,
	input logic [1:0]        i_rresp,
	input logic              i_interrupt,
	input plic_pkg::reg_op_t i_op
);

	import plic_pkg::*;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Response channels under back-pressure
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	bvalid_held: assert property (@(posedge i_clock) disable iff (i_reset)
		i_bvalid && !i_bready |=> i_bvalid && $stable(i_bresp))
		else $error("bvalid dropped or bresp changed before bready");

	rvalid_held: assert property (@(posedge i_clock) disable iff (i_reset)
		i_rvalid && !i_rready |=> i_rvalid && $stable(i_rdata) && $stable(i_rresp))
		else $error("rvalid dropped or read payload changed before rready");

	// Notification is a single-cycle pulse
	irq_one_cycle: assert property (@(posedge i_clock) disable iff (i_reset)
		i_interrupt |=> !i_interrupt)
		else $error("interrupt high for two cycles in a row");

	no_op_while_busy: assert property (@(posedge i_clock) disable iff (i_reset)
		(i_bvalid || i_rvalid) |-> i_op == op_none)
		else $error("op issued while a response was outstanding");

endmodule

`default_nettype wire

// File: sim/plic_tb.sv
// Testbench for the interrupt controller that replays sim/plic_testdata.txt from the project root
`timescale 1ns/1ns
`default_nettype none

`include "plic_macros.svh"

module plic_tb;

	localparam int clock_period = 8;
	localparam int cycles_per_line = 200; // Watchdog budget per command

	logic                         clock;
	logic                         reset;
	logic [`PLIC_NUM_SOURCES-1:0] sources;
	logic                         interrupt_enable;
	logic                         awvalid;
	logic                         awready;
	logic [`PLIC_ADDR_WIDTH-1:0]  awaddr;
	logic                         wvalid;
	logic                         wready;
	logic [31:0]                  wdata;
	logic                         bvalid;
	logic                         bready;
	logic [1:0]                   bresp;
	logic                         arvalid;
	logic                         arready;
	logic [`PLIC_ADDR_WIDTH-1:0]  araddr;
	logic                         rvalid;
	logic                         rready;
	logic [31:0]                  rdata;
	logic [1:0]                   rresp;
	logic                         interrupt;

	int irq_total = 0;   // Pulses seen so far
	int irq_mark = 0;    // Total at the last IRQ command
	int watchdog_ns = 0; // Zero until the data file is sized

	plic_top dut_i (
		.i_clock            (clock),
		.i_reset            (reset),
		.i_sources          (sources),
		.i_interrupt_enable (interrupt_enable),
		.i_awvalid          (awvalid),
		.o_awready          (awready),
		.i_awaddr           (awaddr),
		.i_wvalid           (wvalid),
		.o_wready           (wready),
		.i_wdata            (wdata),
		.o_bvalid           (bvalid),
		.i_bready           (bready),
		.o_bresp            (bresp),
		.i_arvalid          (arvalid),
		.o_arready          (arready),
		.i_araddr           (araddr),
		.o_rvalid           (rvalid),
		.i_rready           (rready),
		.o_rdata            (rdata),
		.o_rresp            (rresp),
		.o_interrupt        (interrupt)
	);

	bind plic_top plic_chk chk_i (
		.i_clock     (i_clock),
		.i_reset     (i_reset),
		.i_bvalid    (o_bvalid),
		.i_bready    (i_bready),
		.i_bresp     (o_bresp),
		.i_rvalid    (o_rvalid),
		.i_rready    (i_rready),
		.i_rdata     (o_rdata),
		.i_rresp     (o_rresp),
		.i_interrupt (o_interrupt),
		.i_op        (op)
	);

	always #(clock_period / 2) clock = ~clock;

	// Pulses counted mid-cycle
	always @(negedge clock) begin
		if (!reset && interrupt) begin
			irq_total <= irq_total + 1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Leaves the caller 1 ns after a rising edge
	task automatic wait_cycles(input int n);
		repeat (n) begin
			@(posedge clock);
			#1;
		end
	endtask

	task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
			input string what);
		if (got !== expected) begin
			$display("Error at %0t ns: %s, got %h, expected %h", $time, what, got, expected);
			$display("Something failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic axi_write(input logic [`PLIC_ADDR_WIDTH-1:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		int unsigned delay;
		delay = $urandom % 4; // bready back-pressure
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		do @(negedge clock); while (!awready);
		check_value(32'(wready), 32'd1, "wready alongside awready");
		wait_cycles(1);
		awvalid = 1'b0;
		wvalid = 1'b0;
		// A claim read offered while bvalid waits must not be taken
		araddr = `PLIC_ADDR_CLAIM;
		arvalid = (delay != 0);
		repeat (delay) begin
			@(negedge clock);
			check_value(32'(arready), 32'd0, "arready while bvalid waits");
			wait_cycles(1);
		end
		arvalid = 1'b0;
		bready = 1'b1;
		do @(negedge clock); while (!bvalid);
		resp = bresp;
		wait_cycles(1);
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [`PLIC_ADDR_WIDTH-1:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		int unsigned delay;
		delay = $urandom % 4; // rready back-pressure
		araddr = addr;
		arvalid = 1'b1;
		do @(negedge clock); while (!arready);
		wait_cycles(1);
		arvalid = 1'b0;
		// A complete write offered while the read is open must not be taken
		awaddr = `PLIC_ADDR_CLAIM;
		wdata = '0;
		awvalid = (delay != 0);
		wvalid = (delay != 0);
		repeat (delay) begin
			@(negedge clock);
			check_value(32'({awready, wready}), 32'd0, "write ready while a read is open");
			wait_cycles(1);
		end
		awvalid = 1'b0;
		wvalid = 1'b0;
		rready = 1'b1;
		do @(negedge clock); while (!rvalid);
		data = rdata;
		resp = rresp;
		wait_cycles(1);
		rready = 1'b0;
	endtask

	function automatic bit is_command(input string text);
		string word;
		if ($sscanf(text, "%s", word) != 1) begin
			return 1'b0; // Blank line
		end
		return word.getc(0) != 8'h23; // Hash starts a comment
	endfunction

	task automatic run_command(input string cmd, input logic [31:0] arg0,
			input logic [31:0] arg1, input logic [31:0] arg2);
		logic [31:0] rd_data;
		logic [1:0]  resp;
		case (cmd)
			"SRC": sources = arg0[`PLIC_NUM_SOURCES-1:0];
			"GIE": interrupt_enable = arg0[0];
			"WAIT": wait_cycles(int'(arg0));
			"WR": begin
				axi_write(arg0[`PLIC_ADDR_WIDTH-1:0], arg1, resp);
				check_value(32'(resp), arg2, $sformatf("bresp of write to %h", arg0));
			end
			"RD": begin
				axi_read(arg0[`PLIC_ADDR_WIDTH-1:0], rd_data, resp);
				check_value(rd_data, arg1, $sformatf("rdata of read from %h", arg0));
				check_value(32'(resp), arg2, $sformatf("rresp of read from %h", arg0));
			end
			"IRQ": begin
				check_value(32'(irq_total - irq_mark), arg0, "interrupt pulse count");
				irq_mark = irq_total;
			end
			default: begin
				$display("Unknown command %s in the test data", cmd);
				$display("Something failed");
				$fatal(1, "bad test data");
			end
		endcase
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Watchdog
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		wait (watchdog_ns > 0);
		#(watchdog_ns);
		$display("Timeout: the test data did not finish within %0d ns", watchdog_ns);
		$display("Something failed");
		$fatal(1, "watchdog expired");
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Main sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		int          fd;
		int          line_count;
		string       line;
		string       cmd;
		logic [31:0] arg0;
		logic [31:0] arg1;
		logic [31:0] arg2;

		clock = 1'b0;
		reset = 1'b1;
		sources = '0;
		interrupt_enable = 1'b0;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		bready = 1'b0;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b0;
		void'($urandom(32'h981));

		// First pass only counts commands
		fd = $fopen("sim/plic_testdata.txt", "r");
		if (fd == 0) begin
			$display("Could not open sim/plic_testdata.txt");
			$display("Something failed");
			$fatal(1, "missing test data");
		end
		line_count = 0;
		while ($fgets(line, fd) != 0) begin
			if (is_command(line)) begin
				line_count++;
			end
		end
		$fclose(fd);
		watchdog_ns = (line_count + 1) * cycles_per_line * clock_period;

		repeat (5) @(posedge clock);
		#1;
		reset = 1'b0;

		fd = $fopen("sim/plic_testdata.txt", "r");
		while ($fgets(line, fd) != 0) begin
			if (is_command(line)) begin
				arg0 = '0;
				arg1 = '0;
				arg2 = '0;
				void'($sscanf(line, "%s %h %h %h", cmd, arg0, arg1, arg2));
				run_command(cmd, arg0, arg1, arg2);
			end
		end
		$fclose(fd);

		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: plic_top.f
+incdir+include
src/plic_pkg.sv
src/plic_gateway.sv
src/plic_pending_arbiter.sv
src/plic_axil_slave.sv
src/plic_top.sv
sim/plic_chk.sv
sim/plic_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the interrupt controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module plic_tb -f plic_top.f \
	--Mdir obj_dir -o plic_sim > build.log 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
	cat build.log
	echo "Build failed with status $build_status"
	exit 1
fi

./obj_dir/plic_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "^Everything OK$" sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation did not report a pass"
	exit 1
fi

// File: sim/plic_testdata.txt
# Command then hex arguments, one per line
# SRC mask | GIE value | WAIT cycles | WR addr data resp | RD addr data resp | IRQ pulses
GIE 1
RD 002000 00000000 0
WR 002000 0000001F 0
RD 002000 0000001E 0
SRC 4
WAIT 8
IRQ 1
RD 001000 00000008 0
SRC 3
WAIT 8
SRC 0
WAIT 4
IRQ 0
RD 001000 0000000E 0
RD 200004 00000001 0
RD 200004 00000002 0
RD 200004 00000003 0
RD 200004 00000000 0
WR 200004 00000003 0
WAIT 4
IRQ 0
SRC 6
WAIT 8
SRC 0
WAIT 4
IRQ 1
RD 200004 00000002 0
WAIT 4
IRQ 0
WR 200004 00000002 0
WAIT 4
IRQ 1
RD 200004 00000003 0
WR 200004 00000003 0
WAIT 4
IRQ 0
GIE 0
SRC F
WAIT 8
IRQ 0
RD 001000 00000000 0
SRC 0
WAIT 4
GIE 1
WAIT 8
IRQ 0
WR 002000 00000004 0
SRC 1
WAIT 8
IRQ 0
RD 001000 00000000 0
SRC 0
RD 002000 00000004 0
RD 003000 00000000 2
WR 001000 FFFFFFFF 2
WR 00ABC0 00000001 2
